// ==== hdl/lite_mux_pkg.sv ====
// Shared constants and channel types for the AXI4-Lite read multiplexer
// Imported by every module that needs port counts, widths or channel structs

package lite_mux_pkg;

  //----------------------------------------
  // Sizes
  //----------------------------------------
  // Manager ports sharing the subordinate
  localparam int unsigned NUM_PORTS = 4;
  localparam int unsigned SEL_W     = $clog2(NUM_PORTS);

  // Outstanding reads at the subordinate port
  localparam int unsigned MAX_TRANS = 4;
  localparam int unsigned PTR_W     = $clog2(MAX_TRANS);

  localparam int unsigned ADDR_W    = 32;
  localparam int unsigned DATA_W    = 32;

  //----------------------------------------
  // Types
  //----------------------------------------
  typedef logic [ADDR_W-1:0]    addr_t;
  typedef logic [DATA_W-1:0]    data_t;
  typedef logic [SEL_W-1:0]     sel_t;
  // One bit per manager port
  typedef logic [NUM_PORTS-1:0] port_vec_t;

  // AR payload, 35 bits
  typedef struct packed {
    addr_t      addr;
    logic [2:0] prot;
  } ar_chan_t;

  // R payload, 34 bits
  typedef struct packed {
    data_t      data;
    logic [1:0] resp;
  } r_chan_t;

endpackage

// ==== hdl/rr_arbiter.sv ====
// Round-robin arbiter over NUM_PORTS valid/ready requesters
// Winner stays locked while its output waits for ready

`timescale 1ns/1ps

module rr_arbiter import lite_mux_pkg::*; #(
  parameter type payload_t = logic
) (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  // Requester side
  input  port_vec_t                 req_i,
  input  payload_t [NUM_PORTS-1:0]  data_i,
  output port_vec_t                 gnt_o,
  // Output side
  output logic                      valid_o,
  input  logic                      ready_i,
  output payload_t                  data_o,
  output sel_t                      idx_o
);

  // Search start, one past last winner
  sel_t prio_q;
  // Held decision while output stalls
  logic lock_q;
  sel_t lock_idx_q;

  sel_t win_idx;
  logic any_req;

  //----------------------------------------
  // Winner selection
  //----------------------------------------
  always_comb begin
    sel_t cand;
    logic found;
    cand    = '0;
    found   = 1'b0;
    win_idx = '0;
    // Scan from prio_q upward with wrap
    for (int i = 0; i < NUM_PORTS; i++) begin
      cand = sel_t'((int'(prio_q) + i) % NUM_PORTS);
      if (!found && req_i[cand]) begin
        win_idx = cand;
        found   = 1'b1;
      end
    end
    any_req = found;
    // Locked index overrides the scan
    if (lock_q) begin
      win_idx = lock_idx_q;
    end
  end

  assign valid_o = lock_q ? req_i[lock_idx_q] : any_req;
  assign data_o  = data_i[win_idx];
  assign idx_o   = win_idx;

  // One-hot grant on the accepted transfer only
  always_comb begin
    gnt_o          = '0;
    gnt_o[win_idx] = valid_o & ready_i;
  end

  //----------------------------------------
  // Priority and lock state
  //----------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      prio_q     <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      lock_q <= valid_o & ~ready_i;
      if (valid_o && !ready_i) begin
        lock_idx_q <= win_idx;
      end
      // Rotate past the port just served
      if (valid_o && ready_i) begin
        prio_q <= (win_idx == sel_t'(NUM_PORTS - 1)) ? '0 : win_idx + 1'b1;
      end
    end
  end

endmodule

// ==== hdl/read_order_queue.sv ====
// In-order record of granted port indices for outstanding reads
// Blocks AR issue when MAX_TRANS reads are in flight

`timescale 1ns/1ps

module read_order_queue import lite_mux_pkg::*; (
  input  logic clk_i,
  input  logic rst_n_i,
  // From arbiter
  input  logic arb_valid_i,
  output logic arb_ready_o,
  input  sel_t arb_idx_i,
  // Toward AR spill register
  output logic iss_valid_o,
  input  logic iss_ready_i,
  // R routing side
  input  logic pop_i,
  output sel_t head_sel_o,
  output logic head_valid_o
);

  // Count reaches MAX_TRANS, so one extra bit
  typedef logic [PTR_W:0] cnt_t;

  // Index storage, payload only
  sel_t             mem_q [MAX_TRANS];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  cnt_t             count_q;

  logic full;
  logic push;

  //----------------------------------------
  // AR handshake gating
  //----------------------------------------
  assign full        = (count_q == cnt_t'(MAX_TRANS));
  assign iss_valid_o = arb_valid_i & ~full;
  assign arb_ready_o = iss_ready_i & ~full;
  // Record only issued ARs
  assign push        = iss_valid_o & iss_ready_i;

  assign head_sel_o   = mem_q[rd_ptr_q];
  assign head_valid_o = (count_q != '0);

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= arb_idx_i;
    end
  end

  //----------------------------------------
  // Pointers and fill level
  //----------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(MAX_TRANS - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(MAX_TRANS - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop leaves count alone
      if (push && !pop_i) begin
        count_q <= count_q + 1'b1;
      end else if (pop_i && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

// ==== hdl/spill_register.sv ====
// Two-slot cut register for a valid/ready channel
// Registers valid, ready and data paths, keeps full throughput

`timescale 1ns/1ps

module spill_register #(
  parameter type data_t_p = logic
) (
  input  logic    clk_i,
  input  logic    rst_n_i,
  // Upstream
  input  logic    valid_i,
  output logic    ready_o,
  input  data_t_p data_i,
  // Downstream
  output logic    valid_o,
  input  logic    ready_i,
  output data_t_p data_o
);

  // Slot A takes new items, slot B holds a stalled one
  logic    a_full_q;
  logic    b_full_q;
  data_t_p a_data_q;
  data_t_p b_data_q;

  logic a_fill;
  logic a_drain;
  logic b_fill;
  logic b_drain;

  //----------------------------------------
  // Slot control
  //----------------------------------------
  assign a_fill  = valid_i & ready_o;
  // A empties whenever B is free
  assign a_drain = a_full_q & ~b_full_q;
  // Spill into B if downstream stalls
  assign b_fill  = a_drain & ~ready_i;
  assign b_drain = b_full_q & ready_i;

  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= data_i;
    end
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill || a_drain) begin
        a_full_q <= a_fill;
      end
      if (b_fill || b_drain) begin
        b_full_q <= b_fill;
      end
    end
  end

  // Outputs from state only, B is older
  assign ready_o = ~a_full_q | ~b_full_q;
  assign valid_o = a_full_q | b_full_q;
  assign data_o  = b_full_q ? b_data_q : a_data_q;

endmodule

// ==== hdl/r_router.sv ====
// Steers read data beats to the manager at the head of the order queue
// Purely combinational, pops the queue on each delivered beat

`timescale 1ns/1ps

module r_router import lite_mux_pkg::*; (
  // From R spill register
  input  logic      rsp_valid_i,
  output logic      rsp_ready_o,
  input  r_chan_t   rsp_i,
  // Order queue head
  input  sel_t      head_sel_i,
  input  logic      head_valid_i,
  // Manager R ports
  output port_vec_t mgr_r_valid_o,
  output r_chan_t   mgr_r_o,
  input  port_vec_t mgr_r_ready_i,
  output logic      pop_o
);

  //----------------------------------------
  // Beat fan-out
  //----------------------------------------
  // Payload broadcast, valid only at head port
  assign mgr_r_o = rsp_i;

  always_comb begin
    mgr_r_valid_o = '0;
    for (int i = 0; i < NUM_PORTS; i++) begin
      mgr_r_valid_o[i] = rsp_valid_i & head_valid_i & (head_sel_i == sel_t'(i));
    end
  end

  // Ready from the addressed manager only
  assign rsp_ready_o = head_valid_i & mgr_r_ready_i[head_sel_i];
  // Beat delivered, retire the entry
  assign pop_o       = rsp_valid_i & rsp_ready_o;

endmodule

// ==== hdl/axi_lite_read_mux.sv ====
// AXI4-Lite read multiplexer, NUM_PORTS managers onto one subordinate
// Round-robin AR arbitration, in-order R return, registered AR and R paths

`timescale 1ns/1ps

module axi_lite_read_mux import lite_mux_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  // Manager AR
  input  port_vec_t                 mgr_ar_valid_i,
  output port_vec_t                 mgr_ar_ready_o,
  input  ar_chan_t [NUM_PORTS-1:0]  mgr_ar_i,
  // Manager R
  output port_vec_t                 mgr_r_valid_o,
  input  port_vec_t                 mgr_r_ready_i,
  output r_chan_t                   mgr_r_o,
  // Subordinate AR
  output logic                      sub_ar_valid_o,
  input  logic                      sub_ar_ready_i,
  output ar_chan_t                  sub_ar_o,
  // Subordinate R
  input  logic                      sub_r_valid_i,
  output logic                      sub_r_ready_o,
  input  r_chan_t                   sub_r_i
);

  // Arbiter output
  logic     arb_valid;
  logic     arb_ready;
  ar_chan_t arb_data;
  sel_t     arb_idx;

  // Gated AR into spill register
  logic     iss_valid;
  logic     iss_ready;

  // R spill register output
  logic     rsp_valid;
  logic     rsp_ready;
  r_chan_t  rsp;

  // Queue head and retire
  sel_t     head_sel;
  logic     head_valid;
  logic     pop;

  //----------------------------------------
  // AR path
  //----------------------------------------
  rr_arbiter #(
    .payload_t ( ar_chan_t )
  ) u_ar_arb (
    .clk_i   ( clk_i          ),
    .rst_n_i ( rst_n_i        ),
    .req_i   ( mgr_ar_valid_i ),
    .data_i  ( mgr_ar_i       ),
    .gnt_o   ( mgr_ar_ready_o ),
    .valid_o ( arb_valid      ),
    .ready_i ( arb_ready      ),
    .data_o  ( arb_data       ),
    .idx_o   ( arb_idx        )
  );

  read_order_queue u_order (
    .clk_i        ( clk_i      ),
    .rst_n_i      ( rst_n_i    ),
    .arb_valid_i  ( arb_valid  ),
    .arb_ready_o  ( arb_ready  ),
    .arb_idx_i    ( arb_idx    ),
    .iss_valid_o  ( iss_valid  ),
    .iss_ready_i  ( iss_ready  ),
    .pop_i        ( pop        ),
    .head_sel_o   ( head_sel   ),
    .head_valid_o ( head_valid )
  );

  spill_register #(
    .data_t_p ( ar_chan_t )
  ) u_ar_spill (
    .clk_i   ( clk_i          ),
    .rst_n_i ( rst_n_i        ),
    .valid_i ( iss_valid      ),
    .ready_o ( iss_ready      ),
    .data_i  ( arb_data       ),
    .valid_o ( sub_ar_valid_o ),
    .ready_i ( sub_ar_ready_i ),
    .data_o  ( sub_ar_o       )
  );

  //----------------------------------------
  // R path
  //----------------------------------------
  spill_register #(
    .data_t_p ( r_chan_t )
  ) u_r_spill (
    .clk_i   ( clk_i         ),
    .rst_n_i ( rst_n_i       ),
    .valid_i ( sub_r_valid_i ),
    .ready_o ( sub_r_ready_o ),
    .data_i  ( sub_r_i       ),
    .valid_o ( rsp_valid     ),
    .ready_i ( rsp_ready     ),
    .data_o  ( rsp           )
  );

  r_router u_r_router (
    .rsp_valid_i   ( rsp_valid     ),
    .rsp_ready_o   ( rsp_ready     ),
    .rsp_i         ( rsp           ),
    .head_sel_i    ( head_sel      ),
    .head_valid_i  ( head_valid    ),
    .mgr_r_valid_o ( mgr_r_valid_o ),
    .mgr_r_o       ( mgr_r_o       ),
    .mgr_r_ready_i ( mgr_r_ready_i ),
    .pop_o         ( pop           )
  );

endmodule

// ==== sim/tb_clk_gen.sv ====
// Free-running testbench clock, 4 ns period
// Starts low, first rising edge at 2 ns

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter time HALF_PERIOD = 2ns
) (
  output logic clk_o
);

  initial clk_o = 1'b0;

  always #(HALF_PERIOD) clk_o = ~clk_o;

endmodule

// ==== sim/tb_axi_lite_read_mux.sv ====
// Testbench for the AXI4-Lite read multiplexer
// Per-port manager drivers, in-order subordinate model, R scoreboards
// Runs five directed and random tests, then prints a summary

`timescale 1ns/1ps

module tb_axi_lite_read_mux import lite_mux_pkg::*; ();

  // Data returned by the subordinate is address XOR this key
  localparam data_t RSP_KEY = 32'hA5C3_5A3C;

  logic      clk;
  logic      rst_n          = 1'b0;
  port_vec_t mgr_ar_valid   = '0;
  ar_chan_t [NUM_PORTS-1:0] mgr_ar = '0;
  port_vec_t mgr_r_ready    = '1;
  logic      sub_ar_ready   = 1'b1;
  logic      sub_r_valid    = 1'b0;
  r_chan_t   sub_r          = '0;

  port_vec_t mgr_ar_ready_o;
  port_vec_t mgr_r_valid_o;
  r_chan_t   mgr_r_o;
  logic      sub_ar_valid_o;
  ar_chan_t  sub_ar_o;
  logic      sub_r_ready_o;

  // Pending reads per port, and issued addresses awaiting R
  addr_t    req_q [NUM_PORTS][$];
  addr_t    exp_q [NUM_PORTS][$];
  // Subordinate accepted ARs, oldest first
  addr_t    sub_q [$];
  ar_chan_t ar_log [$];

  // Test controls
  bit    r_stall_en  = 1'b0;
  bit    ar_stall_en = 1'b0;
  bit    hold_r      = 1'b0;
  bit    log_ar      = 1'b0;
  string cur_test    = "none";

  int unsigned lcg_state   = 29;
  int          outstanding = 0;
  int          max_outst   = 0;
  int          mon_errs    = 0;
  int          seq_errs    = 0;
  int          test_start  = 0;
  int          n_tests     = 0;

  tb_clk_gen u_clk (.clk_o(clk));

  axi_lite_read_mux i_dut (
    .clk_i          ( clk            ),
    .rst_n_i        ( rst_n          ),
    .mgr_ar_valid_i ( mgr_ar_valid   ),
    .mgr_ar_ready_o ( mgr_ar_ready_o ),
    .mgr_ar_i       ( mgr_ar         ),
    .mgr_r_valid_o  ( mgr_r_valid_o  ),
    .mgr_r_ready_i  ( mgr_r_ready    ),
    .mgr_r_o        ( mgr_r_o        ),
    .sub_ar_valid_o ( sub_ar_valid_o ),
    .sub_ar_ready_i ( sub_ar_ready   ),
    .sub_ar_o       ( sub_ar_o       ),
    .sub_r_valid_i  ( sub_r_valid    ),
    .sub_r_ready_o  ( sub_r_ready_o  ),
    .sub_r_i        ( sub_r          )
  );

  //----------------------------------------
  // Reference model and helpers
  //----------------------------------------
  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
  endfunction

  // Expected beat for a read of addr, OKAY response
  function automatic r_chan_t expected_r(input addr_t addr);
    r_chan_t r;
    r.data = addr ^ RSP_KEY;
    r.resp = 2'b00;
    return r;
  endfunction

  task automatic check_r(input string what, input r_chan_t exp, input r_chan_t act,
                         inout int errs);
    if (exp !== act) begin
      errs++;
      $display("[ERROR] %s: expected data %h resp %b, actual data %h resp %b",
               what, exp.data, exp.resp, act.data, act.resp);
    end
  endtask

  task automatic check_ar(input string what, input ar_chan_t exp, input ar_chan_t act,
                          inout int errs);
    if (exp !== act) begin
      errs++;
      $display("[ERROR] %s: expected addr %h prot %b, actual addr %h prot %b",
               what, exp.addr, exp.prot, act.addr, act.prot);
    end
  endtask

  task automatic check_vec(input string what, input port_vec_t exp, input port_vec_t act,
                           inout int errs);
    if (exp !== act) begin
      errs++;
      $display("[ERROR] %s: expected %b, actual %b", what, exp, act);
    end
  endtask

  // Nothing queued, issued or in flight anywhere
  function automatic bit all_idle();
    bit idle;
    idle = (mgr_ar_valid == '0) && !sub_r_valid && (sub_q.size() == 0)
        && !sub_ar_valid_o && (mgr_r_valid_o == '0);
    for (int p = 0; p < NUM_PORTS; p++) begin
      idle = idle && (req_q[p].size() == 0) && (exp_q[p].size() == 0);
    end
    return idle;
  endfunction

  task automatic wait_idle(input int limit);
    int cyc;
    cyc = 0;
    while (!all_idle() && cyc < limit) begin
      @(negedge clk);
      cyc++;
    end
    if (!all_idle()) begin
      seq_errs++;
      $display("Timeout in %s: reads still in flight after %0d cycles", cur_test, limit);
    end
  endtask

  task automatic start_test(input string name);
    cur_test   = name;
    test_start = mon_errs + seq_errs;
    n_tests++;
  endtask

  task automatic end_test();
    int errs;
    errs = mon_errs + seq_errs - test_start;
    $display("test %s: %s, %0d errors", cur_test, (errs == 0) ? "ok" : "FAILED", errs);
  endtask

  //----------------------------------------
  // Manager AR drivers
  //----------------------------------------
  // One read at a time per port, recorded on grant
  always @(posedge clk) begin : ar_drive
    addr_t nxt;
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (rst_n && mgr_ar_valid[p] && mgr_ar_ready_o[p]) begin
        exp_q[p].push_back(mgr_ar[p].addr);
        mgr_ar_valid[p] <= 1'b0;
      end
      if (rst_n && (!mgr_ar_valid[p] || mgr_ar_ready_o[p]) && req_q[p].size() > 0) begin
        nxt = req_q[p].pop_front();
        mgr_ar_valid[p] <= 1'b1;
        mgr_ar[p]       <= '{addr: nxt, prot: 3'(p)};
      end
    end
  end

  //----------------------------------------
  // Manager R monitor
  //----------------------------------------
  always @(posedge clk) begin : r_mon
    if (rst_n) begin
      if ($countones(mgr_r_valid_o) > 1) begin
        mon_errs++;
        $display("[ERROR] %s: expected one R valid bit at most, actual %b",
                 cur_test, mgr_r_valid_o);
      end
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (mgr_r_valid_o[p] && mgr_r_ready[p]) begin
          if (exp_q[p].size() == 0) begin
            mon_errs++;
            $display("%s: port %0d got an R beat it never asked for", cur_test, p);
          end else begin
            check_r($sformatf("%s port %0d", cur_test, p),
                    expected_r(exp_q[p].pop_front()), mgr_r_o, mon_errs);
          end
        end
      end
    end
    mgr_r_ready <= r_stall_en ? port_vec_t'(lcg_next()) : '1;
  end

  //----------------------------------------
  // Subordinate model
  //----------------------------------------
  // Answers in acceptance order after random gaps
  always @(posedge clk) begin : sub_model
    if (rst_n) begin
      if (sub_ar_valid_o && sub_ar_ready) begin
        sub_q.push_back(sub_ar_o.addr);
        if (log_ar) begin
          ar_log.push_back(sub_ar_o);
        end
        outstanding++;
      end
      if (sub_r_valid && sub_r_ready_o) begin
        sub_r_valid <= 1'b0;
        outstanding--;
      end
      if ((!sub_r_valid || sub_r_ready_o) && sub_q.size() > 0 && !hold_r
          && (lcg_next() % 4) != 0) begin
        sub_r_valid <= 1'b1;
        sub_r       <= '{data: sub_q.pop_front() ^ RSP_KEY, resp: 2'b00};
      end
      if (outstanding > max_outst) begin
        max_outst = outstanding;
      end
    end
    sub_ar_ready <= ar_stall_en ? ((lcg_next() % 3) != 0) : 1'b1;
  end

  //----------------------------------------
  // Test sequence
  //----------------------------------------
  initial begin : main_seq
    int       cyc;
    int       total;
    ar_chan_t exp_ar;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;

    // Idle outputs right after reset
    start_test("reset_state");
    repeat (2) @(negedge clk);
    check_vec("reset_state sub_ar_valid", '0, port_vec_t'(sub_ar_valid_o), seq_errs);
    check_vec("reset_state mgr_r_valid", '0, mgr_r_valid_o, seq_errs);
    check_vec("reset_state mgr_ar_ready", '0, mgr_ar_ready_o, seq_errs);
    end_test();

    // One read per port, one port at a time
    start_test("single_reads");
    for (int p = 0; p < NUM_PORTS; p++) begin
      req_q[p].push_back(addr_t'(32'h1000_0000 + 256 * p));
      wait_idle(200);
    end
    end_test();

    // All ports request twice, priority starts at port 0 and rotates
    start_test("rr_order");
    ar_log.delete();
    log_ar = 1'b1;
    for (int n = 0; n < 2; n++) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        req_q[p].push_back(addr_t'(32'h2000_0000 + 64 * n + 16 * p));
      end
    end
    wait_idle(400);
    log_ar = 1'b0;
    if (ar_log.size() != 2 * NUM_PORTS) begin
      seq_errs++;
      $display("[ERROR] %s: expected %0d reads at subordinate, actual %0d", cur_test,
               2 * NUM_PORTS, ar_log.size());
    end else begin
      for (int k = 0; k < 2 * NUM_PORTS; k++) begin
        // Slot k belongs to port k mod NUM_PORTS
        exp_ar.addr = addr_t'(32'h2000_0000 + 64 * (k / NUM_PORTS) + 16 * (k % NUM_PORTS));
        exp_ar.prot = 3'(k % NUM_PORTS);
        check_ar($sformatf("%s slot %0d", cur_test, k), exp_ar, ar_log[k], seq_errs);
      end
    end
    end_test();

    // Random traffic under both kinds of back-pressure
    start_test("random_stalls");
    r_stall_en  = 1'b1;
    ar_stall_en = 1'b1;
    for (int n = 0; n < 10; n++) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        req_q[p].push_back(addr_t'(((lcg_next() << 16) | lcg_next()) & 32'hFFFF_FFFC));
      end
    end
    wait_idle(4000);
    r_stall_en  = 1'b0;
    ar_stall_en = 1'b0;
    end_test();

    // R withheld, outstanding reads must cap at MAX_TRANS
    start_test("max_trans");
    hold_r = 1'b1;
    for (int n = 0; n < 3; n++) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        req_q[p].push_back(addr_t'(32'h3000_0000 + 64 * n + 4 * p));
      end
    end
    cyc = 0;
    while (outstanding < int'(MAX_TRANS) && cyc < 200) begin
      @(negedge clk);
      cyc++;
    end
    if (outstanding < int'(MAX_TRANS)) begin
      seq_errs++;
      $display("Timeout in max_trans: subordinate never filled up with reads");
    end
    // Dwell so any excess AR would show up
    for (int k = 0; k < 30; k++) begin
      @(negedge clk);
    end
    if (max_outst > int'(MAX_TRANS)) begin
      seq_errs++;
      $display("[ERROR] %s: expected at most %0d outstanding, actual %0d", cur_test,
               MAX_TRANS, max_outst);
    end
    hold_r = 1'b0;
    wait_idle(1000);
    end_test();

    total = mon_errs + seq_errs;
    $display("Summary: %0d tests run, %0d errors", n_tests, total);
    if (total == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
hdl/lite_mux_pkg.sv
hdl/rr_arbiter.sv
hdl/read_order_queue.sv
hdl/spill_register.sv
hdl/r_router.sv
hdl/axi_lite_read_mux.sv
sim/tb_clk_gen.sv
sim/tb_axi_lite_read_mux.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
TOP       ?= tb_axi_lite_read_mux
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf $(OBJ_DIR)
